/* logic/csr_macros.svh */
// CSR map, bit positions, cause codes and reset values; include wherever the CSR unit is used
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// machine word width
`define XLEN 32

// machine-mode CSR addresses
`define CSR_MSTATUS  12'h300
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MIP      12'h344
`define CSR_MHARTID  12'hF14

// mstatus fields
`define MSTATUS_MIE    3
`define MSTATUS_MPIE   7
`define MSTATUS_MPP_LO 11

// interrupt enable and pending, external line only
`define MIE_MEIE 11
`define MIP_MEIP 11

// mcause encoding
`define CAUSE_ILLEGAL  4'd2
`define CAUSE_MEXT_INT 4'd11
`define CAUSE_INT_BIT  31

// reset values
// MPP fixed at 2'b11, MIE and MPIE clear
`define MSTATUS_RESET 32'h0000_1800
`define HART_ID       32'h0000_0000

`endif

/* logic/csr_pkg.sv */
// CSR operation codes and instruction word views; import wherever a Zicsr word is decoded
`include "csr_macros.svh"

package csr_pkg;

  // same encoding as funct3 of the SYSTEM opcode
  // 0 and 4 have no Zicsr meaning and decode as illegal
  typedef enum logic [2:0] {
    CSRRW  = 3'd1,
    CSRRS  = 3'd2,
    CSRRC  = 3'd3,
    CSRRWI = 3'd5,
    CSRRSI = 3'd6,
    CSRRCI = 3'd7
  } csr_op_e;

  // I-type layout as used by csrrw and friends
  // rs1 doubles as the 5-bit uimm in the immediate forms
  typedef struct packed {
    logic [11:0] csr;
    logic [4:0]  rs1;
    csr_op_e     funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } csr_fields_t;

  // raw is what lands in mtval on an illegal access,
  // fields is what the decoder looks at
  typedef union packed {
    logic [`XLEN-1:0] raw;
    csr_fields_t      fields;
  } csr_instr_u;

endpackage

/* logic/csr_file.sv */
// machine CSR storage with combinational read; written by CSR instructions, trap entry and mret
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_file (
  input  logic              clk,
  input  logic              reset_x,
  // read port, same cycle
  input  logic [11:0]       rd_addr,
  output logic [`XLEN-1:0]  rd_value,
  output logic              rd_hit,
  // instruction write
  input  logic              wr_en,
  input  logic [11:0]       wr_addr,
  input  logic [`XLEN-1:0]  wr_data,
  // trap entry and return
  input  logic              trap_enter,
  input  logic [`XLEN-1:0]  trap_cause,
  input  logic [`XLEN-1:0]  trap_epc,
  input  logic [`XLEN-1:0]  trap_tval,
  input  logic              tval_en,
  input  logic              mret_commit,
  // interrupt line
  input  logic              ext_irq,
  // state the trap controller needs
  output logic              mstatus_mie,
  output logic              mie_meie,
  output logic              mip_meip,
  output logic [`XLEN-1:0]  mtvec,
  output logic [`XLEN-1:0]  mepc
);

  logic [`XLEN-1:0] mstatus_r;
  logic [`XLEN-1:0] mie_r;
  logic [`XLEN-1:0] mtvec_r;
  logic [`XLEN-1:0] mscratch_r;
  logic [`XLEN-1:0] mepc_r;
  logic [`XLEN-1:0] mcause_r;
  logic [`XLEN-1:0] mtval_r;
  logic             meip_r;
  logic [`XLEN-1:0] mip_value;

  // only MEIP exists in mip
  always_comb begin
    mip_value            = '0;
    mip_value[`MIP_MEIP] = meip_r;
  end

  always_comb begin
    rd_hit   = 1'b1;
    rd_value = '0;
    case (rd_addr)
      `CSR_MSTATUS:  rd_value = mstatus_r;
      `CSR_MIE:      rd_value = mie_r;
      `CSR_MTVEC:    rd_value = mtvec_r;
      `CSR_MSCRATCH: rd_value = mscratch_r;
      `CSR_MEPC:     rd_value = mepc_r;
      `CSR_MCAUSE:   rd_value = mcause_r;
      `CSR_MTVAL:    rd_value = mtval_r;
      `CSR_MIP:      rd_value = mip_value;
      `CSR_MHARTID:  rd_value = `HART_ID;
      default:       rd_hit   = 1'b0;
    endcase
  end

  // external line sampled every cycle, software cannot touch it
  always_ff @(posedge clk) begin
    if (!reset_x) begin
      meip_r <= 1'b0;
    end else begin
      meip_r <= ext_irq;
    end
  end

  // trap entry beats mret beats an instruction write
  always_ff @(posedge clk) begin
    if (!reset_x) begin
      mstatus_r  <= `MSTATUS_RESET;
      mie_r      <= '0;
      mtvec_r    <= '0;
      mscratch_r <= '0;
      mepc_r     <= '0;
      mcause_r   <= '0;
      mtval_r    <= '0;
    end else if (trap_enter) begin
      mepc_r                  <= trap_epc;
      mcause_r                <= trap_cause;
      mtval_r                 <= tval_en ? trap_tval : '0;
      mstatus_r[`MSTATUS_MPIE] <= mstatus_r[`MSTATUS_MIE];
      mstatus_r[`MSTATUS_MIE]  <= 1'b0;
    end else if (mret_commit) begin
      mstatus_r[`MSTATUS_MIE]  <= mstatus_r[`MSTATUS_MPIE];
      mstatus_r[`MSTATUS_MPIE] <= 1'b1;
    end else if (wr_en) begin
      case (wr_addr)
        // MPP is hardwired, only the two enable bits take the write
        `CSR_MSTATUS: begin
          mstatus_r[`MSTATUS_MIE]  <= wr_data[`MSTATUS_MIE];
          mstatus_r[`MSTATUS_MPIE] <= wr_data[`MSTATUS_MPIE];
        end
        `CSR_MIE:      mie_r      <= wr_data;
        `CSR_MTVEC:    mtvec_r    <= wr_data;
        `CSR_MSCRATCH: mscratch_r <= wr_data;
        `CSR_MEPC:     mepc_r     <= wr_data;
        `CSR_MCAUSE:   mcause_r   <= wr_data;
        `CSR_MTVAL:    mtval_r    <= wr_data;
        // mip and mhartid ignore writes
        default: ;
      endcase
    end
  end

  assign mstatus_mie = mstatus_r[`MSTATUS_MIE];
  assign mie_meie    = mie_r[`MIE_MEIE];
  assign mip_meip    = meip_r;
  assign mtvec       = mtvec_r;
  assign mepc        = mepc_r;

endmodule

/* logic/csr_alu.sv */
// Zicsr decode, legality check and read-modify-write value for one CSR instruction
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_alu (
  input  logic                csr_valid,
  input  csr_pkg::csr_instr_u csr_instr,
  input  logic [`XLEN-1:0]    rs1_data,
  // read side of the register block
  output logic [11:0]         rd_addr,
  input  logic [`XLEN-1:0]    old_value,
  input  logic                rd_hit,
  // candidate write toward the trap controller
  output logic                alu_wr_en,
  output logic [11:0]         alu_wr_addr,
  output logic [`XLEN-1:0]    alu_wr_data,
  output logic                illegal,
  output logic [`XLEN-1:0]    rd_data
);

  import csr_pkg::*;

  logic [`XLEN-1:0] operand;
  logic             rs1_zero;
  logic             writes;
  logic             bad_op;
  logic             ro_write;

  assign rd_addr     = csr_instr.fields.csr;
  assign alu_wr_addr = csr_instr.fields.csr;
  assign rs1_zero    = (csr_instr.fields.rs1 == 5'd0);

  // funct3[2] picks the immediate forms
  assign operand = csr_instr.fields.funct3[2] ? {{(`XLEN-5){1'b0}}, csr_instr.fields.rs1}
                                              : rs1_data;

  always_comb begin
    bad_op      = 1'b0;
    writes      = 1'b0;
    alu_wr_data = operand;
    case (csr_instr.fields.funct3)
      CSRRW, CSRRWI: begin
        writes      = 1'b1;
        alu_wr_data = operand;
      end
      // set and clear with a zero source are pure reads
      CSRRS, CSRRSI: begin
        writes      = !rs1_zero;
        alu_wr_data = old_value | operand;
      end
      CSRRC, CSRRCI: begin
        writes      = !rs1_zero;
        alu_wr_data = old_value & ~operand;
      end
      default: bad_op = 1'b1;
    endcase
  end

  assign ro_write = writes && (csr_instr.fields.csr == `CSR_MHARTID);

  assign illegal   = csr_valid && (bad_op || !rd_hit || ro_write);
  assign alu_wr_en = csr_valid && writes && !illegal;

  // old value goes back to rd even when the access traps
  assign rd_data = old_value;

endmodule

/* logic/trap_ctrl.sv */
// trap arbitration: picks exception, interrupt, mret or CSR write and forms cause and redirect
`timescale 1ns/100ps
`include "csr_macros.svh"

module trap_ctrl (
  input  logic                csr_valid,
  input  csr_pkg::csr_instr_u csr_instr,
  input  logic                illegal,
  // candidate write from the instruction unit
  input  logic                alu_wr_en,
  input  logic [11:0]         alu_wr_addr,
  input  logic [`XLEN-1:0]    alu_wr_data,
  // write actually committed to the register block
  output logic                wr_en,
  output logic [11:0]         wr_addr,
  output logic [`XLEN-1:0]    wr_data,
  // pipeline events
  input  logic [`XLEN-1:0]    pc,
  input  logic                exc_valid,
  input  logic [3:0]          exc_cause,
  input  logic [`XLEN-1:0]    exc_tval,
  input  logic                mret,
  input  logic                irq_accept,
  // CSR state
  input  logic                mstatus_mie,
  input  logic                mie_meie,
  input  logic                mip_meip,
  input  logic [`XLEN-1:0]    mtvec,
  input  logic [`XLEN-1:0]    mepc,
  // trap state update
  output logic                trap_enter,
  output logic [`XLEN-1:0]    trap_cause,
  output logic [`XLEN-1:0]    trap_epc,
  output logic [`XLEN-1:0]    trap_tval,
  output logic                tval_en,
  output logic                mret_commit,
  // redirect, same cycle as the event
  output logic                trap_taken,
  output logic [`XLEN-1:0]    trap_pc,
  output logic [`XLEN-1:0]    mret_pc,
  output logic                irq_pending
);

  logic             csr_exc;
  logic             sync_exc;
  logic             irq_take;
  logic [3:0]       code;
  logic [`XLEN-1:0] base;

  assign csr_exc     = csr_valid && illegal;
  assign sync_exc    = exc_valid || csr_exc;
  assign irq_pending = mstatus_mie && mie_meie && mip_meip;

  // interrupt only when nothing synchronous is in this cycle
  assign irq_take = irq_pending && irq_accept && !sync_exc;

  assign trap_enter  = sync_exc || irq_take;
  assign mret_commit = mret && !trap_enter;
  assign trap_taken  = trap_enter;

  // a trap or mret kills the CSR write of the same cycle
  assign wr_en   = alu_wr_en && !trap_enter && !mret;
  assign wr_addr = alu_wr_addr;
  assign wr_data = alu_wr_data;

  // the pipeline exception outranks an illegal CSR access
  always_comb begin
    if (exc_valid) begin
      code      = exc_cause;
      trap_tval = exc_tval;
      tval_en   = (exc_cause == `CAUSE_ILLEGAL);
    end else if (csr_exc) begin
      code      = `CAUSE_ILLEGAL;
      trap_tval = csr_instr.raw;
      tval_en   = 1'b1;
    end else begin
      code      = `CAUSE_MEXT_INT;
      trap_tval = '0;
      tval_en   = 1'b0;
    end
  end

  always_comb begin
    trap_cause                 = {{(`XLEN-4){1'b0}}, code};
    trap_cause[`CAUSE_INT_BIT] = irq_take;
  end

  assign trap_epc = pc;

  // vectored mode offsets interrupts only
  assign base = {mtvec[`XLEN-1:2], 2'b00};
  always_comb begin
    if (mtvec[0] && irq_take) begin
      trap_pc = base + {{(`XLEN-6){1'b0}}, code, 2'b00};
    end else begin
      trap_pc = base;
    end
  end

  assign mret_pc = mepc;

endmodule

/* logic/csr_unit.sv */
// top of the machine CSR subsystem; the pipeline drives instructions, events and the irq line
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_unit (
  input  logic                clk,
  input  logic                reset_x,
  input  logic                csr_valid,
  input  csr_pkg::csr_instr_u csr_instr,
  input  logic [`XLEN-1:0]    rs1_data,
  input  logic [`XLEN-1:0]    pc,
  input  logic                exc_valid,
  input  logic [3:0]          exc_cause,
  input  logic [`XLEN-1:0]    exc_tval,
  input  logic                mret,
  input  logic                irq_accept,
  input  logic                ext_irq,
  output logic [`XLEN-1:0]    rd_data,
  output logic                trap_taken,
  output logic [`XLEN-1:0]    trap_pc,
  output logic [`XLEN-1:0]    mret_pc,
  output logic                irq_pending
);

  // read path
  logic [11:0]      rd_addr;
  logic [`XLEN-1:0] rd_value;
  logic             rd_hit;
  // candidate and committed writes
  logic             alu_wr_en;
  logic [11:0]      alu_wr_addr;
  logic [`XLEN-1:0] alu_wr_data;
  logic             illegal;
  logic             wr_en;
  logic [11:0]      wr_addr;
  logic [`XLEN-1:0] wr_data;
  // trap update
  logic             trap_enter;
  logic [`XLEN-1:0] trap_cause;
  logic [`XLEN-1:0] trap_epc;
  logic [`XLEN-1:0] trap_tval;
  logic             tval_en;
  logic             mret_commit;
  // state for arbitration
  logic             mstatus_mie;
  logic             mie_meie;
  logic             mip_meip;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;

  csr_file u_file (
    .clk         (clk),
    .reset_x     (reset_x),
    .rd_addr     (rd_addr),
    .rd_value    (rd_value),
    .rd_hit      (rd_hit),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .trap_enter  (trap_enter),
    .trap_cause  (trap_cause),
    .trap_epc    (trap_epc),
    .trap_tval   (trap_tval),
    .tval_en     (tval_en),
    .mret_commit (mret_commit),
    .ext_irq     (ext_irq),
    .mstatus_mie (mstatus_mie),
    .mie_meie    (mie_meie),
    .mip_meip    (mip_meip),
    .mtvec       (mtvec),
    .mepc        (mepc)
  );

  csr_alu u_alu (
    .csr_valid   (csr_valid),
    .csr_instr   (csr_instr),
    .rs1_data    (rs1_data),
    .rd_addr     (rd_addr),
    .old_value   (rd_value),
    .rd_hit      (rd_hit),
    .alu_wr_en   (alu_wr_en),
    .alu_wr_addr (alu_wr_addr),
    .alu_wr_data (alu_wr_data),
    .illegal     (illegal),
    .rd_data     (rd_data)
  );

  trap_ctrl u_trap (
    .csr_valid   (csr_valid),
    .csr_instr   (csr_instr),
    .illegal     (illegal),
    .alu_wr_en   (alu_wr_en),
    .alu_wr_addr (alu_wr_addr),
    .alu_wr_data (alu_wr_data),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .pc          (pc),
    .exc_valid   (exc_valid),
    .exc_cause   (exc_cause),
    .exc_tval    (exc_tval),
    .mret        (mret),
    .irq_accept  (irq_accept),
    .mstatus_mie (mstatus_mie),
    .mie_meie    (mie_meie),
    .mip_meip    (mip_meip),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .trap_enter  (trap_enter),
    .trap_cause  (trap_cause),
    .trap_epc    (trap_epc),
    .trap_tval   (trap_tval),
    .tval_en     (tval_en),
    .mret_commit (mret_commit),
    .trap_taken  (trap_taken),
    .trap_pc     (trap_pc),
    .mret_pc     (mret_pc),
    .irq_pending (irq_pending)
  );

endmodule

/* verif/csr_unit_tb.sv */
// self-checking testbench for the CSR unit; a shadow model predicts outputs every cycle
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_unit_tb;

  import csr_pkg::*;

  logic             clk = 1'b0;
  logic             reset_x;
  logic             csr_valid;
  csr_instr_u       csr_instr;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] pc;
  logic             exc_valid;
  logic [3:0]       exc_cause;
  logic [`XLEN-1:0] exc_tval;
  logic             mret;
  logic             irq_accept;
  logic             ext_irq;
  logic [`XLEN-1:0] rd_data;
  logic             trap_taken;
  logic [`XLEN-1:0] trap_pc;
  logic [`XLEN-1:0] mret_pc;
  logic             irq_pending;

  // shadow copy of the machine CSRs
  logic [`XLEN-1:0] s_mstatus;
  logic [`XLEN-1:0] s_mie;
  logic [`XLEN-1:0] s_mtvec;
  logic [`XLEN-1:0] s_mscratch;
  logic [`XLEN-1:0] s_mepc;
  logic [`XLEN-1:0] s_mcause;
  logic [`XLEN-1:0] s_mtval;
  logic             s_meip;

  logic [31:0] lcg_state = 32'hd447_0a8e;
  int          mismatch_count = 0;
  int          timeout_count = 0;

  csr_unit dut (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic csr_instr_u make_instr(input logic [2:0] f3, input logic [11:0] addr,
                                            input logic [4:0] src);
    csr_instr_u w;
    // SYSTEM opcode with rd fixed at x1
    w.raw = {addr, src, f3, 5'd1, 7'h73};
    return w;
  endfunction

  function automatic logic [2:0] pick_op(input logic [31:0] r);
    case (r[15:0] % 16'd6)
      16'd0:   return CSRRW;
      16'd1:   return CSRRS;
      16'd2:   return CSRRC;
      16'd3:   return CSRRWI;
      16'd4:   return CSRRSI;
      default: return CSRRCI;
    endcase
  endfunction

  function automatic logic [11:0] pick_addr(input logic [3:0] k);
    case (k)
      4'd0:    return `CSR_MSTATUS;
      4'd1:    return `CSR_MIE;
      4'd2:    return `CSR_MTVEC;
      4'd3:    return `CSR_MSCRATCH;
      4'd4:    return `CSR_MEPC;
      4'd5:    return `CSR_MCAUSE;
      4'd6:    return `CSR_MTVAL;
      4'd7:    return `CSR_MIP;
      default: return `CSR_MHARTID;
    endcase
  endfunction

  function automatic void reset_shadow();
    s_mstatus  = `MSTATUS_RESET;
    s_mie      = '0;
    s_mtvec    = '0;
    s_mscratch = '0;
    s_mepc     = '0;
    s_mcause   = '0;
    s_mtval    = '0;
    s_meip     = 1'b0;
  endfunction

  function automatic void shadow_read(input logic [11:0] a, output logic hit,
                                      output logic [31:0] v);
    hit = 1'b1;
    v   = '0;
    case (a)
      `CSR_MSTATUS:  v = s_mstatus;
      `CSR_MIE:      v = s_mie;
      `CSR_MTVEC:    v = s_mtvec;
      `CSR_MSCRATCH: v = s_mscratch;
      `CSR_MEPC:     v = s_mepc;
      `CSR_MCAUSE:   v = s_mcause;
      `CSR_MTVAL:    v = s_mtval;
      `CSR_MIP:      v[`MIP_MEIP] = s_meip;
      `CSR_MHARTID:  v = '0;
      default:       hit = 1'b0;
    endcase
  endfunction

  function automatic void shadow_write(input logic [11:0] a, input logic [31:0] v);
    case (a)
      // MPP stays 2'b11 and only MIE and MPIE take writes
      `CSR_MSTATUS: begin
        s_mstatus[`MSTATUS_MIE]  = v[`MSTATUS_MIE];
        s_mstatus[`MSTATUS_MPIE] = v[`MSTATUS_MPIE];
      end
      `CSR_MIE:      s_mie = v;
      `CSR_MTVEC:    s_mtvec = v;
      `CSR_MSCRATCH: s_mscratch = v;
      `CSR_MEPC:     s_mepc = v;
      `CSR_MCAUSE:   s_mcause = v;
      `CSR_MTVAL:    s_mtval = v;
      default: ;
    endcase
  endfunction

  // expected outputs for this cycle and the shadow state after the next edge
  function automatic void ref_step(output logic [31:0] e_rd, output logic e_taken,
                                   output logic [31:0] e_tpc, output logic [31:0] e_mpc,
                                   output logic e_pend);
    logic [11:0] a;
    logic [2:0]  f3;
    logic [4:0]  src;
    logic        hit;
    logic        writes;
    logic        bad;
    logic        ill;
    logic        exc;
    logic        irq;
    logic [3:0]  code;
    logic [31:0] old;
    logic [31:0] opnd;
    logic [31:0] wval;
    logic [31:0] tval;
    a   = csr_instr.fields.csr;
    f3  = csr_instr.fields.funct3;
    src = csr_instr.fields.rs1;
    shadow_read(a, hit, old);
    opnd   = f3[2] ? {27'd0, src} : rs1_data;
    writes = 1'b0;
    bad    = 1'b0;
    wval   = opnd;
    case (f3)
      3'd1, 3'd5: writes = 1'b1;
      3'd2, 3'd6: begin
        writes = (src != 5'd0);
        wval   = old | opnd;
      end
      3'd3, 3'd7: begin
        writes = (src != 5'd0);
        wval   = old & ~opnd;
      end
      default: bad = 1'b1;
    endcase
    ill    = csr_valid && (bad || !hit || (writes && a == `CSR_MHARTID));
    exc    = exc_valid || ill;
    e_pend = s_mstatus[`MSTATUS_MIE] && s_mie[`MIE_MEIE] && s_meip;
    irq    = e_pend && irq_accept && !exc;
    if (exc_valid) begin
      code = exc_cause;
      tval = (exc_cause == `CAUSE_ILLEGAL) ? exc_tval : '0;
    end else if (ill) begin
      code = `CAUSE_ILLEGAL;
      tval = csr_instr.raw;
    end else begin
      code = `CAUSE_MEXT_INT;
      tval = '0;
    end
    e_rd    = old;
    e_taken = exc || irq;
    e_mpc   = s_mepc;
    e_tpc   = {s_mtvec[31:2], 2'b00};
    if (s_mtvec[0] && irq) begin
      e_tpc = e_tpc + {26'd0, code, 2'b00};
    end
    if (e_taken) begin
      s_mepc   = pc;
      s_mcause = {irq, 27'd0, code};
      s_mtval  = tval;
      s_mstatus[`MSTATUS_MPIE] = s_mstatus[`MSTATUS_MIE];
      s_mstatus[`MSTATUS_MIE]  = 1'b0;
    end else if (mret) begin
      s_mstatus[`MSTATUS_MIE]  = s_mstatus[`MSTATUS_MPIE];
      s_mstatus[`MSTATUS_MPIE] = 1'b1;
    end else if (csr_valid && writes && !ill) begin
      shadow_write(a, wval);
    end
    s_meip = ext_irq;
  endfunction

  task automatic check_word(input string name, input logic [`XLEN-1:0] expected,
                            input logic [`XLEN-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected %08h, got %08h", $time, name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
    end
  endtask

  // outputs settle half a cycle after the drive
  always @(negedge clk) begin : compare_outputs
    logic [31:0] e_rd;
    logic [31:0] e_tpc;
    logic [31:0] e_mpc;
    logic        e_taken;
    logic        e_pend;
    if (!reset_x) begin
      reset_shadow();
    end else begin
      ref_step(e_rd, e_taken, e_tpc, e_mpc, e_pend);
      if (csr_valid) begin
        check_word("rd_data", e_rd, rd_data);
      end
      check_bit("trap_taken", e_taken, trap_taken);
      if (e_taken) begin
        check_word("trap_pc", e_tpc, trap_pc);
      end
      check_word("mret_pc", e_mpc, mret_pc);
      check_bit("irq_pending", e_pend, irq_pending);
    end
  end

  task automatic drive_defaults();
    csr_valid  <= 1'b0;
    csr_instr  <= '0;
    rs1_data   <= '0;
    pc         <= '0;
    exc_valid  <= 1'b0;
    exc_cause  <= '0;
    exc_tval   <= '0;
    mret       <= 1'b0;
    irq_accept <= 1'b0;
  endtask

  // ext_irq is a level and keeps its value across cycles
  task automatic begin_cycle();
    @(posedge clk);
    drive_defaults();
  endtask

  task automatic issue(input csr_instr_u w, input logic [`XLEN-1:0] data);
    begin_cycle();
    csr_valid <= 1'b1;
    csr_instr <= w;
    rs1_data  <= data;
  endtask

  task automatic read_expect(input logic [11:0] addr, input string name,
                             input logic [`XLEN-1:0] expected);
    issue(make_instr(CSRRS, addr, 5'd0), '0);
    @(negedge clk);
    check_word(name, expected, rd_data);
  endtask

  task automatic check_cause(input logic [`XLEN-1:0] expected);
    issue(make_instr(CSRRS, `CSR_MCAUSE, 5'd0), '0);
    @(negedge clk);
    if (rd_data !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: mcause expected %08h, got %08h", $time, expected, rd_data);
    end
  endtask

  task automatic check_illegal(input csr_instr_u w);
    issue(w, 32'hffff_ffff);
    @(negedge clk);
    check_bit("trap_taken", 1'b1, trap_taken);
    check_cause(32'd2);
    read_expect(`CSR_MTVAL, "mtval", w.raw);
    read_expect(`CSR_MSCRATCH, "mscratch", 32'h0bad_f00d);
  endtask

  // idle cycles until irq_pending reaches the level
  task automatic wait_irq_level(input logic level);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 20) begin
      begin_cycle();
      @(negedge clk);
      seen = (irq_pending === level);
      n++;
    end
    if (!seen) begin
      timeout_count++;
      $display("timeout at %0t: irq_pending never reached %0b within 20 cycles", $time, level);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [4:0]  src;
    drive_defaults();
    ext_irq <= 1'b0;
    reset_x <= 1'b0;
    repeat (10) @(posedge clk);
    reset_x <= 1'b1;

    // reset values of every address
    for (int i = 0; i < 9; i++) begin
      issue(make_instr(CSRRS, pick_addr(4'(i)), 5'd0), '0);
    end
    read_expect(`CSR_MSTATUS, "mstatus", `MSTATUS_RESET);

    // random back-to-back traffic with about a quarter at rs1 = 0
    for (int i = 0; i < 200; i++) begin
      r   = lcg_next();
      src = (r[21:20] == 2'b00) ? 5'd0 : r[26:22];
      issue(make_instr(pick_op(r), pick_addr({1'b0, r[18:16]}), src), lcg_next());
    end
    for (int i = 0; i < 9; i++) begin
      issue(make_instr(CSRRS, pick_addr(4'(i)), 5'd0), '0);
    end

    // set and clear with rs1 = 0 must not write
    issue(make_instr(CSRRW, `CSR_MSCRATCH, 5'd1), 32'h0bad_f00d);
    issue(make_instr(CSRRS, `CSR_MSCRATCH, 5'd0), 32'hffff_ffff);
    issue(make_instr(CSRRC, `CSR_MSCRATCH, 5'd0), 32'hffff_ffff);
    read_expect(`CSR_MSCRATCH, "mscratch", 32'h0bad_f00d);
    issue(make_instr(CSRRW, `CSR_MIE, 5'd1), '0);
    issue(make_instr(CSRRW, `CSR_MSTATUS, 5'd1), '0);
    issue(make_instr(CSRRW, `CSR_MTVEC, 5'd1), 32'h0000_0100);

    // illegal accesses
    check_illegal(make_instr(CSRRW, 12'h7c0, 5'd3));
    check_illegal(make_instr(3'd0, `CSR_MSCRATCH, 5'd3));
    check_illegal(make_instr(3'd4, `CSR_MSCRATCH, 5'd3));
    check_illegal(make_instr(CSRRW, `CSR_MHARTID, 5'd3));
    read_expect(`CSR_MHARTID, "mhartid", `HART_ID);

    // exception entry and mret
    issue(make_instr(CSRRSI, `CSR_MSTATUS, 5'd8), '0);
    begin_cycle();
    exc_valid <= 1'b1;
    exc_cause <= 4'd5;
    exc_tval  <= 32'h1111_2222;
    pc        <= 32'h2000_0040;
    @(negedge clk);
    check_bit("trap_taken", 1'b1, trap_taken);
    check_word("trap_pc", 32'h0000_0100, trap_pc);
    read_expect(`CSR_MEPC, "mepc", 32'h2000_0040);
    check_cause(32'd5);
    read_expect(`CSR_MTVAL, "mtval", 32'h0);
    read_expect(`CSR_MSTATUS, "mstatus", 32'h0000_1880);
    begin_cycle();
    mret <= 1'b1;
    @(negedge clk);
    check_word("mret_pc", 32'h2000_0040, mret_pc);
    check_bit("trap_taken", 1'b0, trap_taken);
    read_expect(`CSR_MSTATUS, "mstatus", 32'h0000_1888);

    // the exception kills the write of the same cycle
    issue(make_instr(CSRRW, `CSR_MSCRATCH, 5'd1), 32'h1234_5678);
    exc_valid <= 1'b1;
    exc_cause <= `CAUSE_ILLEGAL;
    exc_tval  <= 32'hdead_beef;
    pc        <= 32'h2000_0080;
    @(negedge clk);
    check_bit("trap_taken", 1'b1, trap_taken);
    read_expect(`CSR_MSCRATCH, "mscratch", 32'h0bad_f00d);
    check_cause(32'd2);
    read_expect(`CSR_MTVAL, "mtval", 32'hdead_beef);

    // external interrupt in direct mode
    issue(make_instr(CSRRW, `CSR_MIE, 5'd1), 32'h0000_0800);
    begin_cycle();
    mret <= 1'b1;
    begin_cycle();
    ext_irq <= 1'b1;
    wait_irq_level(1'b1);
    begin_cycle();
    irq_accept <= 1'b1;
    pc         <= 32'h3000_0000;
    @(negedge clk);
    check_bit("trap_taken", 1'b1, trap_taken);
    check_word("trap_pc", 32'h0000_0100, trap_pc);
    check_cause(32'h8000_000b);
    check_bit("irq_pending", 1'b0, irq_pending);
    read_expect(`CSR_MEPC, "mepc", 32'h3000_0000);

    // exception beats a pending interrupt
    begin_cycle();
    mret <= 1'b1;
    wait_irq_level(1'b1);
    begin_cycle();
    irq_accept <= 1'b1;
    exc_valid  <= 1'b1;
    exc_cause  <= 4'd7;
    pc         <= 32'h3000_0010;
    @(negedge clk);
    check_bit("trap_taken", 1'b1, trap_taken);
    check_cause(32'd7);

    // in vectored mode the interrupt goes to base + 4 * 11
    issue(make_instr(CSRRW, `CSR_MTVEC, 5'd1), 32'h0000_0101);
    begin_cycle();
    mret <= 1'b1;
    wait_irq_level(1'b1);
    begin_cycle();
    irq_accept <= 1'b1;
    @(negedge clk);
    check_word("trap_pc", 32'h0000_012c, trap_pc);
    check_cause(32'h8000_000b);
    begin_cycle();
    mret <= 1'b1;
    wait_irq_level(1'b1);
    begin_cycle();
    irq_accept <= 1'b1;
    exc_valid  <= 1'b1;
    exc_cause  <= 4'd1;
    @(negedge clk);
    check_word("trap_pc", 32'h0000_0100, trap_pc);
    check_cause(32'd1);

    begin_cycle();
    ext_irq <= 1'b0;
    begin_cycle();
    begin_cycle();
    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+logic
logic/csr_pkg.sv
logic/csr_file.sv
logic/csr_alu.sv
logic/trap_ctrl.sv
logic/csr_unit.sv
verif/csr_unit_tb.sv

/* Makefile */
TOP = csr_unit_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f flist.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir
